//--- files.f
hdl/rv_isa_pkg.sv
hdl/sched_pkg.sv
hdl/dispatch_select.sv
hdl/alu_unit.sv
hdl/mem_unit.sv
hdl/result_arbiter.sv
hdl/reorder_station.sv
hdl/sched_core_top.sv
tests/tb_sched_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_sched_core
FILELIST  := files.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

//--- tests/tb_sched_core.sv
module tb_sched_core
    import rv_isa_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROB_DEPTH = 8;
    localparam int DMEM_WORDS = 16;
    localparam int ISSUE_TIMEOUT = 200;   // cycles
    localparam int DRAIN_TIMEOUT = 2000;

    logic                clk_in;
    logic                rst_in;
    logic                issue_valid;
    opcode_e             issue_op;
    alu_fn_e             issue_fn;
    logic [REG_ID_W-1:0] issue_rs1;
    logic [REG_ID_W-1:0] issue_rs2;
    logic [REG_ID_W-1:0] issue_rd;
    logic [XLEN-1:0]     issue_imm;
    logic [XLEN-1:0]     rf_rs1_val;
    logic [XLEN-1:0]     rf_rs2_val;
    logic                issue_ready;
    logic [REG_ID_W-1:0] rf_rs1_id;
    logic [REG_ID_W-1:0] rf_rs2_id;
    logic                commit_valid;
    logic [REG_ID_W-1:0] commit_rd;
    logic [XLEN-1:0]     commit_value;

    logic [XLEN-1:0]     rf      [32];          // register file seen by the DUT
    logic [XLEN-1:0]     ref_rf  [32];          // sequential model state
    logic [XLEN-1:0]     ref_mem [DMEM_WORDS];
    logic [REG_ID_W-1:0] exp_rd_q [$];
    logic [XLEN-1:0]     exp_val_q [$];
    int                  issued_cnt;
    int                  committed_cnt;
    logic                saw_full;

    sched_core_top #(.ROB_DEPTH(ROB_DEPTH), .DMEM_WORDS(DMEM_WORDS)) i_dut (.*);

    assign rf_rs1_val = rf[rf_rs1_id];
    assign rf_rs2_val = rf[rf_rs2_id];

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] exp);
        fail_with($sformatf("[FAIL] %0t ns %s: got 0x%08h, expected 0x%08h",
                            $time, name, got, exp));
    endtask

    function automatic logic [XLEN-1:0] alu_ref(input alu_fn_e fn, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        case (fn)
            fn_add:  return a + b;
            fn_sub:  return a - b;
            fn_and:  return a & b;
            fn_or:   return a | b;
            fn_xor:  return a ^ b;
            fn_sll:  return a << b[4:0];
            fn_srl:  return a >> b[4:0];
            fn_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    // runs one instruction in program order on the model state
    function automatic void ref_exec(input opcode_e op, input alu_fn_e fn,
                                     input logic [4:0] rs1, input logic [4:0] rs2,
                                     input logic [4:0] rd, input logic [XLEN-1:0] imm,
                                     output logic [4:0] exp_rd, output logic [XLEN-1:0] exp_val);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        int              idx;
        a   = ref_rf[rs1];
        b   = ref_rf[rs2];
        idx = int'(((a + imm) >> 2) % DMEM_WORDS);  // word index wraps
        case (op)
            op_reg:  exp_val = alu_ref(fn, a, b);
            op_imm:  exp_val = alu_ref(fn, a, imm);
            op_load: exp_val = ref_mem[idx];
            default: begin
                ref_mem[idx] = b;
                exp_val      = '0;  // a store reports zero
            end
        endcase
        exp_rd = (op == op_store) ? 5'd0 : rd;
        if (op != op_store && rd != 0) ref_rf[rd] = exp_val;
    endfunction

    // called on a falling edge and returns on the falling edge after acceptance
    task automatic issue_one(input opcode_e op, input alu_fn_e fn, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [4:0] rd,
                             input logic [XLEN-1:0] imm);
        int              waited;
        logic [4:0]      exp_rd;
        logic [XLEN-1:0] exp_val;
        waited      = 0;
        issue_valid = 1'b1;
        issue_op    = op;
        issue_fn    = fn;
        issue_rs1   = rs1;
        issue_rs2   = rs2;
        issue_rd    = rd;
        issue_imm   = imm;
        while (!issue_ready) begin
            assert (waited < ISSUE_TIMEOUT) else
                fail_with("timeout: issue_ready stayed low while an instruction waited");
            waited++;
            saw_full = 1'b1;
            @(negedge clk_in);
        end
        ref_exec(op, fn, rs1, rs2, rd, imm, exp_rd, exp_val);
        exp_rd_q.push_back(exp_rd);
        exp_val_q.push_back(exp_val);
        @(posedge clk_in);
        issued_cnt++;
        @(negedge clk_in);
        issue_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk_in);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_rd_q.size() != 0) begin
            assert (waited < DRAIN_TIMEOUT) else
                fail_with("timeout: issued instructions did not all commit");
            waited++;
            @(posedge clk_in);
        end
        @(negedge clk_in);
    endtask

    task automatic alu_function_sweep();
        issue_one(op_imm, fn_add, 0, 0, 1, 32'h1234_5678);
        issue_one(op_imm, fn_add, 0, 0, 2, 32'hf000_0013);
        for (int f = 0; f < 8; f++) begin
            issue_one(op_reg, alu_fn_e'(f), 1, 2, 5'(3 + f), '0);
            idle_cycles(f % 2);
            issue_one(op_imm, alu_fn_e'(f), 2, 0, 5'(11 + f), 32'h8000_0007);
        end
    endtask

    task automatic dependent_chains();
        for (int i = 0; i < 10; i++) begin
            issue_one(op_imm, alu_fn_e'(i % 5), 20, 0, 20, 32'(i * 3 + 1));  // back to back
        end
        issue_one(op_reg, fn_xor, 20, 1, 21, '0);
        issue_one(op_reg, fn_sub, 21, 20, 20, '0);
        issue_one(op_reg, fn_slt, 20, 21, 21, '0);
        issue_one(op_reg, fn_sll, 20, 21, 20, '0);
    endtask

    task automatic x0_source_reads();
        issue_one(op_imm, fn_add, 0, 0, 0, 32'h55);
        issue_one(op_reg, fn_or, 0, 0, 22, '0);
        issue_one(op_imm, fn_add, 0, 0, 23, 32'd9);
        issue_one(op_reg, fn_add, 23, 0, 24, '0);
    endtask

    task automatic store_load_pairs();
        issue_one(op_store, fn_add, 0, 1, 0, 32'd4);
        issue_one(op_store, fn_add, 0, 2, 0, 32'd8);
        issue_one(op_load, fn_add, 0, 0, 25, 32'd4);
        issue_one(op_load, fn_add, 0, 0, 26, 32'd8);
        issue_one(op_load, fn_add, 0, 0, 27, 32'd12);   // never written
        issue_one(op_store, fn_add, 0, 23, 0, 32'd68);  // aliases word 1
        issue_one(op_load, fn_add, 0, 0, 28, 32'd4);
        issue_one(op_imm, fn_add, 0, 0, 29, 32'h40);
        issue_one(op_load, fn_add, 29, 0, 30, 32'd8);
        issue_one(op_load, fn_add, 0, 0, 31, 32'd60);
    endtask

    task automatic fill_station();
        saw_full = 1'b0;
        for (int i = 0; i < 20; i++) begin
            if (i % 2 == 0) begin
                issue_one(op_load, fn_add, 29, 0, 5'(8 + i % 4), 32'(i * 4));
            end else begin
                issue_one(op_reg, fn_add, 5'(8 + (i - 1) % 4), 20, 20, '0);
            end
        end
        assert (saw_full) else fail_with("issue_ready never fell during the issue burst");
    endtask

    task automatic random_mix();
        opcode_e         op;
        alu_fn_e         fn;
        logic [XLEN-1:0] imm;
        for (int n = 0; n < 300; n++) begin
            op  = opcode_e'($urandom_range(3, 0));
            fn  = alu_fn_e'($urandom_range(7, 0));
            imm = (op == op_load || op == op_store) ? $urandom_range(127, 0) : $urandom;
            issue_one(op, fn, 5'($urandom_range(7, 0)), 5'($urandom_range(7, 0)),
                      5'($urandom_range(7, 0)), imm);
            if ($urandom_range(3, 0) == 0) idle_cycles($urandom_range(3, 1));
        end
    endtask

    always @(negedge clk_in) begin : check_commit
        logic [REG_ID_W-1:0] exp_rd;
        logic [XLEN-1:0]     exp_val;
        if (!rst_in) begin
            assert (issued_cnt - committed_cnt <= ROB_DEPTH) else
                fail_with("station accepted more instructions than it has entries");
            if (commit_valid) begin
                assert (exp_rd_q.size() != 0) else
                    fail_with("commit seen with no instruction outstanding");
                exp_rd  = exp_rd_q.pop_front();
                exp_val = exp_val_q.pop_front();
                assert (commit_rd == exp_rd) else report_mismatch("commit_rd", commit_rd, exp_rd);
                assert (commit_value == exp_val) else
                    report_mismatch("commit_value", commit_value, exp_val);
                if (commit_rd != 0) rf[commit_rd] = commit_value;  // x0 stays zero
                committed_cnt++;
            end
        end
    end

    initial begin
        void'($urandom(32'hfc8b5b4a));
        rst_in        = 1'b1;
        issue_valid   = 1'b0;
        issue_op      = op_reg;
        issue_fn      = fn_add;
        issue_rs1     = '0;
        issue_rs2     = '0;
        issue_rd      = '0;
        issue_imm     = '0;
        issued_cnt    = 0;
        committed_cnt = 0;
        saw_full      = 1'b0;
        for (int r = 0; r < 32; r++) begin
            rf[r]     = '0;
            ref_rf[r] = '0;
        end
        for (int m = 0; m < DMEM_WORDS; m++) begin
            ref_mem[m] = '0;
        end
        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        alu_function_sweep();
        dependent_chains();
        x0_source_reads();
        store_load_pairs();
        wait_drain();
        fill_station();
        wait_drain();
        random_mix();
        wait_drain();
        idle_cycles(10);  // no stray commits after the last one

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- hdl/sched_core_top.sv
module sched_core_top
    import rv_isa_pkg::*;
#(
    parameter int ROB_DEPTH = 8,
    parameter int DMEM_WORDS = 16
) (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                issue_valid,
    input  opcode_e             issue_op,
    input  alu_fn_e             issue_fn,
    input  logic [REG_ID_W-1:0] issue_rs1,
    input  logic [REG_ID_W-1:0] issue_rs2,
    input  logic [REG_ID_W-1:0] issue_rd,
    input  logic [XLEN-1:0]     issue_imm,
    input  logic [XLEN-1:0]     rf_rs1_val,
    input  logic [XLEN-1:0]     rf_rs2_val,
    output logic                issue_ready,
    output logic [REG_ID_W-1:0] rf_rs1_id,
    output logic [REG_ID_W-1:0] rf_rs2_id,
    output logic                commit_valid,
    output logic [REG_ID_W-1:0] commit_rd,
    output logic [XLEN-1:0]     commit_value
);
    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic [ROB_DEPTH-1:0] alu_ready_vec;
    logic [ROB_DEPTH-1:0] mem_ready_vec;
    logic                 alu_sel_valid;
    logic [TAG_W-1:0]     alu_sel_tag;
    logic                 mem_sel_valid;
    logic [TAG_W-1:0]     mem_sel_tag;
    logic                 alu_req;
    logic                 alu_ack;
    logic [TAG_W-1:0]     alu_tag;
    alu_fn_e              alu_fn;
    logic [XLEN-1:0]      alu_a;
    logic [XLEN-1:0]      alu_b;
    logic                 mem_req;
    logic                 mem_ack;
    logic [TAG_W-1:0]     mem_tag;
    logic                 mem_is_store;
    logic [XLEN-1:0]      mem_base;
    logic [XLEN-1:0]      mem_offset;
    logic [XLEN-1:0]      mem_data;
    logic                 alu_wb_req;
    logic                 alu_wb_ack;
    logic [TAG_W-1:0]     alu_wb_tag;
    logic [XLEN-1:0]      alu_wb_value;
    logic                 mem_wb_req;
    logic                 mem_wb_ack;
    logic [TAG_W-1:0]     mem_wb_tag;
    logic [XLEN-1:0]      mem_wb_value;
    logic                 bus_valid;
    logic [TAG_W-1:0]     bus_tag;
    logic [XLEN-1:0]      bus_value;

    reorder_station #(.ROB_DEPTH(ROB_DEPTH)) u_station (.*);

    dispatch_select #(.ROB_DEPTH(ROB_DEPTH)) u_alu_select (
        .ready_vec (alu_ready_vec),
        .sel_valid (alu_sel_valid),
        .sel_tag   (alu_sel_tag)
    );

    dispatch_select #(.ROB_DEPTH(ROB_DEPTH)) u_mem_select (
        .ready_vec (mem_ready_vec),
        .sel_valid (mem_sel_valid),
        .sel_tag   (mem_sel_tag)
    );

    alu_unit #(.ROB_DEPTH(ROB_DEPTH)) u_alu (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .req      (alu_req),
        .tag      (alu_tag),
        .fn       (alu_fn),
        .a        (alu_a),
        .b        (alu_b),
        .wb_ack   (alu_wb_ack),
        .ack      (alu_ack),
        .wb_req   (alu_wb_req),
        .wb_tag   (alu_wb_tag),
        .wb_value (alu_wb_value)
    );

    mem_unit #(.ROB_DEPTH(ROB_DEPTH), .DMEM_WORDS(DMEM_WORDS)) u_mem (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .req      (mem_req),
        .tag      (mem_tag),
        .is_store (mem_is_store),
        .base     (mem_base),
        .offset   (mem_offset),
        .data     (mem_data),
        .wb_ack   (mem_wb_ack),
        .ack      (mem_ack),
        .wb_req   (mem_wb_req),
        .wb_tag   (mem_wb_tag),
        .wb_value (mem_wb_value)
    );

    result_arbiter #(.ROB_DEPTH(ROB_DEPTH)) u_arbiter (.*);

endmodule

//--- hdl/reorder_station.sv
module reorder_station
    import rv_isa_pkg::*;
    import sched_pkg::*;
#(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                issue_valid,
    input  opcode_e             issue_op,
    input  alu_fn_e             issue_fn,
    input  logic [REG_ID_W-1:0] issue_rs1,
    input  logic [REG_ID_W-1:0] issue_rs2,
    input  logic [REG_ID_W-1:0] issue_rd,
    input  logic [XLEN-1:0]     issue_imm,
    input  logic [XLEN-1:0]     rf_rs1_val,
    input  logic [XLEN-1:0]     rf_rs2_val,
    input  logic                alu_sel_valid,
    input  logic [TAG_W-1:0]    alu_sel_tag,
    input  logic                mem_sel_valid,
    input  logic [TAG_W-1:0]    mem_sel_tag,
    input  logic                alu_ack,
    input  logic                mem_ack,
    input  logic                bus_valid,
    input  logic [TAG_W-1:0]    bus_tag,
    input  logic [XLEN-1:0]     bus_value,
    output logic                issue_ready,
    output logic [REG_ID_W-1:0] rf_rs1_id,
    output logic [REG_ID_W-1:0] rf_rs2_id,
    output logic                commit_valid,
    output logic [REG_ID_W-1:0] commit_rd,
    output logic [XLEN-1:0]     commit_value,
    output logic [ROB_DEPTH-1:0] alu_ready_vec,
    output logic [ROB_DEPTH-1:0] mem_ready_vec,
    output logic                alu_req,
    output logic [TAG_W-1:0]    alu_tag,
    output alu_fn_e             alu_fn,
    output logic [XLEN-1:0]     alu_a,
    output logic [XLEN-1:0]     alu_b,
    output logic                mem_req,
    output logic [TAG_W-1:0]    mem_tag,
    output logic                mem_is_store,
    output logic [XLEN-1:0]     mem_base,
    output logic [XLEN-1:0]     mem_offset,
    output logic [XLEN-1:0]     mem_data
);
    localparam int CNT_W = TAG_W + 1;
    localparam int NREG = 2 ** REG_ID_W;

    entry_state_e        state_q [ROB_DEPTH];
    unit_e               unit_q  [ROB_DEPTH];
    opcode_e             op_q    [ROB_DEPTH];
    alu_fn_e             fn_q    [ROB_DEPTH];
    logic [REG_ID_W-1:0] rd_q    [ROB_DEPTH];
    logic [XLEN-1:0]     imm_q   [ROB_DEPTH];
    logic [XLEN-1:0]     v1_q    [ROB_DEPTH];
    logic [XLEN-1:0]     v2_q    [ROB_DEPTH];
    logic [XLEN-1:0]     res_q   [ROB_DEPTH];
    logic                r1_q    [ROB_DEPTH];  // operand present
    logic                r2_q    [ROB_DEPTH];
    logic                mr_q    [ROB_DEPTH];  // previous memory op done
    logic [TAG_W-1:0]    t1_q    [ROB_DEPTH];  // producer tags
    logic [TAG_W-1:0]    t2_q    [ROB_DEPTH];
    logic [TAG_W-1:0]    mt_q    [ROB_DEPTH];
    logic                pend_q  [NREG];       // register has an uncommitted producer
    logic [TAG_W-1:0]    ptag_q  [NREG];
    logic [TAG_W-1:0]    head_q;
    logic [TAG_W-1:0]    tail_q;
    logic [TAG_W-1:0]    last_mem_q;
    logic [CNT_W-1:0]    count_q;
    logic                alu_busy_q;
    logic                mem_busy_q;

    logic [REG_ID_W-1:0] src_id  [2];
    logic [XLEN-1:0]     src_rf  [2];
    logic [XLEN-1:0]     src_val [2];
    logic                src_rdy [2];
    logic [TAG_W-1:0]    src_tag [2];
    logic [ROB_DEPTH-1:0] entry_rdy;
    logic                issue_fire;
    logic                issue_is_mem;
    logic                mem_pred_done;
    logic                alu_go;
    logic                mem_go;

    assign issue_ready  = count_q != CNT_W'(ROB_DEPTH);
    assign issue_fire   = issue_valid && issue_ready;
    assign issue_is_mem = (issue_op == op_load) || (issue_op == op_store);
    assign rf_rs1_id    = issue_rs1;
    assign rf_rs2_id    = issue_rs2;
    assign src_id[0]    = issue_rs1;
    assign src_id[1]    = issue_rs2;
    assign src_rf[0]    = rf_rs1_val;
    assign src_rf[1]    = rf_rs2_val;

    assign commit_valid = state_q[head_q] == st_done;
    assign commit_rd    = (op_q[head_q] == op_store) ? '0 : rd_q[head_q];
    assign commit_value = res_q[head_q];

    // a refilled alu entry or a committed slot no longer orders memory
    assign mem_pred_done = state_q[last_mem_q] == st_empty || state_q[last_mem_q] == st_done
                        || unit_q[last_mem_q] != unit_mem
                        || (bus_valid && bus_tag == last_mem_q);

    assign alu_go = alu_sel_valid && !alu_req && !alu_ack;
    assign mem_go = mem_sel_valid && !mem_req && !mem_ack;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_tag[s] = ptag_q[src_id[s]];
            src_rdy[s] = 1'b1;
            src_val[s] = src_rf[s];
            if (src_id[s] == '0) begin
                src_val[s] = '0;
            end else if (pend_q[src_id[s]]) begin
                if (state_q[src_tag[s]] == st_done) begin
                    src_val[s] = res_q[src_tag[s]];
                end else if (bus_valid && bus_tag == src_tag[s]) begin
                    src_val[s] = bus_value;  // same-cycle forward
                end else begin
                    src_rdy[s] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            entry_rdy[i] = state_q[i] == st_waiting && r1_q[i] && r2_q[i] && mr_q[i]
                        && (op_q[i] != op_store || TAG_W'(i) == head_q);
            alu_ready_vec[i] = entry_rdy[i] && unit_q[i] == unit_alu && !alu_busy_q;
            mem_ready_vec[i] = entry_rdy[i] && unit_q[i] == unit_mem && !mem_busy_q;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            head_q     <= '0;
            tail_q     <= '0;
            last_mem_q <= '0;
            count_q    <= '0;
            alu_busy_q <= 1'b0;
            mem_busy_q <= 1'b0;
            alu_req    <= 1'b0;
            mem_req    <= 1'b0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                state_q[i] <= st_empty;
            end
            for (int r = 0; r < NREG; r++) begin
                pend_q[r] <= 1'b0;
            end
        end else begin
            count_q <= count_q + CNT_W'(issue_fire) - CNT_W'(commit_valid);

            if (commit_valid) begin
                state_q[head_q] <= st_empty;
                head_q          <= head_q + 1'b1;
                if (ptag_q[rd_q[head_q]] == head_q) pend_q[rd_q[head_q]] <= 1'b0;
            end

            if (bus_valid) begin
                state_q[bus_tag] <= st_done;
                res_q[bus_tag]   <= bus_value;
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    if (state_q[i] == st_waiting) begin
                        if (!r1_q[i] && t1_q[i] == bus_tag) begin
                            v1_q[i] <= bus_value;
                            r1_q[i] <= 1'b1;
                        end
                        if (!r2_q[i] && t2_q[i] == bus_tag) begin
                            v2_q[i] <= bus_value;
                            r2_q[i] <= 1'b1;
                        end
                        if (!mr_q[i] && mt_q[i] == bus_tag) mr_q[i] <= 1'b1;
                    end
                end
                if (alu_busy_q && bus_tag == alu_tag) alu_busy_q <= 1'b0;
                if (mem_busy_q && bus_tag == mem_tag) mem_busy_q <= 1'b0;
            end

            // issue comes after commit so a same-cycle rename of rd wins
            if (issue_fire) begin
                state_q[tail_q] <= st_waiting;
                unit_q[tail_q]  <= issue_is_mem ? unit_mem : unit_alu;
                op_q[tail_q]    <= issue_op;
                fn_q[tail_q]    <= issue_fn;
                rd_q[tail_q]    <= issue_rd;
                imm_q[tail_q]   <= issue_imm;
                v1_q[tail_q]    <= src_val[0];
                r1_q[tail_q]    <= src_rdy[0];
                t1_q[tail_q]    <= src_tag[0];
                v2_q[tail_q]    <= src_val[1];
                r2_q[tail_q]    <= src_rdy[1];
                t2_q[tail_q]    <= src_tag[1];
                mr_q[tail_q]    <= issue_is_mem ? mem_pred_done : 1'b1;
                mt_q[tail_q]    <= last_mem_q;
                if (issue_is_mem) last_mem_q <= tail_q;
                if (issue_op != op_store) begin
                    pend_q[issue_rd] <= 1'b1;
                    ptag_q[issue_rd] <= tail_q;
                end
                tail_q <= tail_q + 1'b1;
            end

            if (alu_req && alu_ack) begin
                alu_req <= 1'b0;
            end else if (alu_go) begin
                alu_req                <= 1'b1;
                alu_busy_q             <= 1'b1;
                state_q[alu_sel_tag]   <= st_executing;
                alu_tag                <= alu_sel_tag;
                alu_fn                 <= fn_q[alu_sel_tag];
                alu_a                  <= v1_q[alu_sel_tag];
                alu_b <= (op_q[alu_sel_tag] == op_imm) ? imm_q[alu_sel_tag] : v2_q[alu_sel_tag];
            end

            if (mem_req && mem_ack) begin
                mem_req <= 1'b0;
            end else if (mem_go) begin
                mem_req              <= 1'b1;
                mem_busy_q           <= 1'b1;
                state_q[mem_sel_tag] <= st_executing;
                mem_tag              <= mem_sel_tag;
                mem_is_store         <= op_q[mem_sel_tag] == op_store;
                mem_base             <= v1_q[mem_sel_tag];
                mem_offset           <= imm_q[mem_sel_tag];
                mem_data             <= v2_q[mem_sel_tag];
            end
        end
    end

endmodule

//--- hdl/result_arbiter.sv
module result_arbiter
    import rv_isa_pkg::*;
    import sched_pkg::*;
#(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             alu_wb_req,
    input  logic [TAG_W-1:0] alu_wb_tag,
    input  logic [XLEN-1:0]  alu_wb_value,
    input  logic             mem_wb_req,
    input  logic [TAG_W-1:0] mem_wb_tag,
    input  logic [XLEN-1:0]  mem_wb_value,
    output logic             alu_wb_ack,
    output logic             mem_wb_ack,
    output logic             bus_valid,
    output logic [TAG_W-1:0] bus_tag,
    output logic [XLEN-1:0]  bus_value
);
    unit_e last_q;  // winner of the previous grant
    logic  alu_pend;
    logic  mem_pend;
    logic  grant_alu;
    logic  grant_mem;

    assign alu_pend  = alu_wb_req && !alu_wb_ack;
    assign mem_pend  = mem_wb_req && !mem_wb_ack;
    assign grant_alu = alu_pend && (!mem_pend || last_q == unit_mem);
    assign grant_mem = mem_pend && !grant_alu;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            bus_valid  <= 1'b0;
            alu_wb_ack <= 1'b0;
            mem_wb_ack <= 1'b0;
            last_q     <= unit_mem;  // alu goes first after reset
        end else begin
            bus_valid <= grant_alu || grant_mem;
            if (grant_alu) begin
                alu_wb_ack <= 1'b1;
                last_q     <= unit_alu;
            end else if (!alu_wb_req) begin
                alu_wb_ack <= 1'b0;
            end
            if (grant_mem) begin
                mem_wb_ack <= 1'b1;
                last_q     <= unit_mem;
            end else if (!mem_wb_req) begin
                mem_wb_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (grant_alu) begin
            bus_tag   <= alu_wb_tag;
            bus_value <= alu_wb_value;
        end else if (grant_mem) begin
            bus_tag   <= mem_wb_tag;
            bus_value <= mem_wb_value;
        end
    end

endmodule

//--- hdl/mem_unit.sv
module mem_unit
    import rv_isa_pkg::*;
#(
    parameter int ROB_DEPTH = 8,
    parameter int DMEM_WORDS = 16,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             req,
    input  logic [TAG_W-1:0] tag,
    input  logic             is_store,
    input  logic [XLEN-1:0]  base,
    input  logic [XLEN-1:0]  offset,
    input  logic [XLEN-1:0]  data,
    input  logic             wb_ack,
    output logic             ack,
    output logic             wb_req,
    output logic [TAG_W-1:0] wb_tag,
    output logic [XLEN-1:0]  wb_value
);
    localparam int IDX_W = $clog2(DMEM_WORDS);

    typedef enum logic [1:0] {s_idle, s_access, s_wb, s_release} state_e;

    state_e           state_q;
    logic [XLEN-1:0]  mem_q [DMEM_WORDS];
    logic             store_q;
    logic [XLEN-1:0]  base_q;
    logic [XLEN-1:0]  offset_q;
    logic [XLEN-1:0]  data_q;
    logic [XLEN-1:0]  addr;
    logic [IDX_W-1:0] idx;
    logic             take;

    assign take = (state_q == s_idle) && req && !ack;
    assign addr = base_q + offset_q;
    assign idx  = addr[IDX_W+1:2];  // byte address to word, wraps at DMEM_WORDS

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state_q <= s_idle;
            ack     <= 1'b0;
            wb_req  <= 1'b0;
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            if (ack && !req) ack <= 1'b0;
            unique case (state_q)
                s_idle: begin
                    if (take) begin
                        ack     <= 1'b1;
                        state_q <= s_access;
                    end
                end
                s_access: begin
                    if (store_q) mem_q[idx] <= data_q;
                    wb_req  <= 1'b1;
                    state_q <= s_wb;
                end
                s_wb: begin
                    if (wb_ack) begin
                        wb_req  <= 1'b0;
                        state_q <= s_release;
                    end
                end
                s_release: begin
                    if (!wb_ack) state_q <= s_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (take) begin
            wb_tag   <= tag;
            store_q  <= is_store;
            base_q   <= base;
            offset_q <= offset;
            data_q   <= data;
        end
        if (state_q == s_access) wb_value <= store_q ? '0 : mem_q[idx];  // stores report zero
    end

endmodule

//--- hdl/alu_unit.sv
module alu_unit
    import rv_isa_pkg::*;
#(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             req,
    input  logic [TAG_W-1:0] tag,
    input  alu_fn_e          fn,
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    input  logic             wb_ack,
    output logic             ack,
    output logic             wb_req,
    output logic [TAG_W-1:0] wb_tag,
    output logic [XLEN-1:0]  wb_value
);
    typedef enum logic [1:0] {s_idle, s_exec, s_wb, s_release} state_e;

    state_e          state_q;
    alu_fn_e         fn_q;
    logic [XLEN-1:0] a_q;
    logic [XLEN-1:0] b_q;
    logic [XLEN-1:0] result;
    logic            take;

    assign take = (state_q == s_idle) && req && !ack;

    always_comb begin
        unique case (fn_q)
            fn_add: result = a_q + b_q;
            fn_sub: result = a_q - b_q;
            fn_and: result = a_q & b_q;
            fn_or:  result = a_q | b_q;
            fn_xor: result = a_q ^ b_q;
            fn_sll: result = a_q << b_q[4:0];
            fn_srl: result = a_q >> b_q[4:0];
            fn_slt: result = {{(XLEN-1){1'b0}}, $signed(a_q) < $signed(b_q)};
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state_q <= s_idle;
            ack     <= 1'b0;
            wb_req  <= 1'b0;
        end else begin
            if (ack && !req) begin
                ack <= 1'b0;  // dispatch handshake closes on its own
            end
            unique case (state_q)
                s_idle: begin
                    if (take) begin
                        ack     <= 1'b1;
                        state_q <= s_exec;
                    end
                end
                s_exec: begin
                    wb_req  <= 1'b1;
                    state_q <= s_wb;
                end
                s_wb: begin
                    if (wb_ack) begin
                        wb_req  <= 1'b0;
                        state_q <= s_release;
                    end
                end
                s_release: begin
                    if (!wb_ack) state_q <= s_idle;  // free again only after ack falls
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (take) begin
            wb_tag <= tag;
            fn_q   <= fn;
            a_q    <= a;
            b_q    <= b;
        end
        if (state_q == s_exec) wb_value <= result;
    end

endmodule

//--- hdl/dispatch_select.sv
module dispatch_select #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic [ROB_DEPTH-1:0] ready_vec,
    output logic                 sel_valid,
    output logic [TAG_W-1:0]     sel_tag
);
    localparam int HALF = ROB_DEPTH / 2;

    logic             any_q [ROB_DEPTH];  // node or anything below it is ready
    logic [TAG_W-1:0] id_q  [ROB_DEPTH];

    // heap layout: node i has children 2i and 2i+1, node 0 sits above node 1
    for (genvar i = HALF; i < ROB_DEPTH; i++) begin : g_leaf
        assign any_q[i] = ready_vec[i];
        assign id_q[i]  = TAG_W'(i);
    end

    for (genvar i = 1; i < HALF; i++) begin : g_node
        assign any_q[i] = ready_vec[i] || any_q[2*i] || any_q[2*i+1];
        assign id_q[i]  = ready_vec[i] ? TAG_W'(i)
                        : any_q[2*i]   ? id_q[2*i] : id_q[2*i+1];  // left child wins
    end

    assign any_q[0] = ready_vec[0] || any_q[1];
    assign id_q[0]  = ready_vec[0] ? '0 : id_q[1];

    assign sel_valid = any_q[0];
    assign sel_tag   = id_q[0];

endmodule

//--- hdl/sched_pkg.sv
package sched_pkg;

    typedef enum logic [1:0] {
        st_empty,
        st_waiting,    // issued, operands may still be missing
        st_executing,  // handed to a unit
        st_done        // result on hand, waiting for commit
    } entry_state_e;

    typedef enum logic {
        unit_alu,
        unit_mem
    } unit_e;

endpackage

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN = 32;     // one data word
    localparam int REG_ID_W = 5;  // x0..x31

    typedef enum logic [1:0] {
        op_reg,   // register-register alu
        op_imm,   // register-immediate alu
        op_load,
        op_store
    } opcode_e;

    typedef enum logic [2:0] {
        fn_add,
        fn_sub,
        fn_and,
        fn_or,
        fn_xor,
        fn_sll,
        fn_srl,
        fn_slt    // signed compare
    } alu_fn_e;

endpackage
